// ==== hw/core_pkg.sv ====
package core_pkg;

    // Bubble markers carried down the pipeline in place of a real instruction
    localparam logic [31:0] REGPC_NOP = 32'hffff_ffff;
    localparam logic [31:0] INST_NOP  = 32'h0000_0013;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    localparam int MEM_WORDS   = 32;
    localparam int MEM_LATENCY = 2;
    localparam int MEM_ADDR_W  = $clog2(MEM_WORDS);
    localparam int MEM_CNT_W   = $clog2(MEM_LATENCY + 1);

    localparam logic FETCH_WAIT_READY = 1'b0;
    localparam logic FETCH_WAIT_VALID = 1'b1;

    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    // One instruction word seen through the I-type and the U-type layout
    typedef union packed {
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } inst_u;

endpackage

// ==== hw/inst_mem.sv ====
module inst_mem import core_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        mem_start,
    input  logic [31:0] mem_addr,
    output logic        mem_ready,
    output logic [31:0] mem_data,
    output logic        mem_data_valid
);

    logic [31:0]           rom [MEM_WORDS];
    logic [MEM_ADDR_W-1:0] word_addr;
    logic [MEM_CNT_W-1:0]  count;
    logic                  busy;
    logic                  accept;
    logic                  done;

    initial begin
        $readmemh("prog.hex", rom);
    end

    assign accept    = mem_start && mem_ready;
    assign done      = busy && (count == MEM_CNT_W'(1));
    assign mem_ready = !busy;

    // The answer is presented in the same cycle that ready comes back
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy           <= 1'b0;
            count          <= '0;
            mem_data_valid <= 1'b0;
        end else begin
            mem_data_valid <= done;
            if (accept) begin
                busy  <= 1'b1;
                count <= MEM_CNT_W'(MEM_LATENCY - 1);
            end else if (done) begin
                busy  <= 1'b0;
            end else if (busy) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            word_addr <= mem_addr[MEM_ADDR_W+1:2];
        end
        if (done) begin
            mem_data <= rom[word_addr];
        end
    end

endmodule

// ==== hw/fetch_stage.sv ====
module fetch_stage import core_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        stall,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        mem_ready,
    input  logic [31:0] mem_data,
    input  logic        mem_data_valid,
    output logic        mem_start,
    output logic [31:0] mem_addr,
    output logic [31:0] id_pc,
    output logic [31:0] id_inst
);

    logic        state;
    logic [31:0] pc;
    logic        fetched;
    logic [31:0] saved_pc;
    logic [31:0] saved_inst;

    logic        take_data;
    logic        have_word;
    logic        issue;
    logic [31:0] next_pc;
    logic [31:0] out_pc;
    logic [31:0] out_inst;

    // A returned word is only taken when nothing is already held
    assign take_data = (state == FETCH_WAIT_VALID) && !fetched && mem_data_valid;
    assign have_word = take_data || ((state == FETCH_WAIT_VALID) && fetched);

    // The word leaves for decode only when the pipeline is free to take it
    assign issue = have_word && !stall && !redirect;

    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (take_data) begin
            next_pc = pc + 32'd4;
        end else begin
            next_pc = pc;
        end
    end

    // A new request follows once the current word has been handed on
    always_comb begin
        if (state == FETCH_WAIT_READY) begin
            mem_start = mem_ready;
        end else begin
            mem_start = have_word && !stall && mem_ready;
        end
    end

    assign mem_addr = next_pc;

    always_comb begin
        if (!issue) begin
            out_pc   = REGPC_NOP;
            out_inst = INST_NOP;
        end else if (take_data) begin
            out_pc   = pc;
            out_inst = mem_data;
        end else begin
            out_pc   = saved_pc;
            out_inst = saved_inst;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= FETCH_WAIT_READY;
            pc      <= RESET_PC;
            fetched <= 1'b0;
            id_pc   <= REGPC_NOP;
            id_inst <= INST_NOP;
        end else begin
            id_pc   <= out_pc;
            id_inst <= out_inst;
            pc      <= next_pc;
            if (state == FETCH_WAIT_READY) begin
                if (mem_ready) begin
                    state   <= FETCH_WAIT_VALID;
                    fetched <= 1'b0;
                end
            end else if (redirect || (have_word && !stall)) begin
                // Any held or returning word is dropped on redirect
                fetched <= 1'b0;
                state   <= mem_start ? FETCH_WAIT_VALID : FETCH_WAIT_READY;
            end else if (take_data) begin
                fetched <= 1'b1;
            end
        end
    end

    // Word held across a stall, with the pc it was fetched from
    always_ff @(posedge clk) begin
        if (take_data && stall && !redirect) begin
            saved_pc   <= pc;
            saved_inst <= mem_data;
        end
    end

endmodule

// ==== hw/decode_stage.sv ====
module decode_stage import core_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] id_pc,
    input  logic [31:0] id_inst,
    output logic        dec_valid,
    output logic [31:0] dec_pc,
    output logic [31:0] dec_inst,
    output logic [4:0]  dec_rd,
    output logic [4:0]  dec_rs1,
    output logic [31:0] dec_imm
);

    inst_u       inst;
    logic        is_u_type;
    logic [4:0]  rs1;
    logic [31:0] imm;

    assign inst = id_inst;

    // LUI and AUIPC carry the upper immediate and read no source register
    assign is_u_type = (inst.u.opcode == OPC_LUI) || (inst.u.opcode == OPC_AUIPC);

    always_comb begin
        if (is_u_type) begin
            rs1 = 5'd0;
            imm = {inst.u.imm20, 12'h000};
        end else begin
            rs1 = inst.i.rs1;
            imm = {{20{inst.i.imm12[11]}}, inst.i.imm12};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= (id_pc != REGPC_NOP);
        end
    end

    always_ff @(posedge clk) begin
        dec_pc   <= id_pc;
        dec_inst <= id_inst;
        dec_rd   <= inst.u.rd;
        dec_rs1  <= rs1;
        dec_imm  <= imm;
    end

endmodule

// ==== hw/frontend_top.sv ====
module frontend_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        stall,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output logic        dec_valid,
    output logic [31:0] dec_pc,
    output logic [31:0] dec_inst,
    output logic [4:0]  dec_rd,
    output logic [4:0]  dec_rs1,
    output logic [31:0] dec_imm
);

    logic        mem_start;
    logic [31:0] mem_addr;
    logic        mem_ready;
    logic [31:0] mem_data;
    logic        mem_data_valid;
    logic [31:0] id_pc;
    logic [31:0] id_inst;

    fetch_stage u_fetch (
        .clk            (clk),
        .arst_n         (arst_n),
        .stall          (stall),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .mem_ready      (mem_ready),
        .mem_data       (mem_data),
        .mem_data_valid (mem_data_valid),
        .mem_start      (mem_start),
        .mem_addr       (mem_addr),
        .id_pc          (id_pc),
        .id_inst        (id_inst)
    );

    inst_mem u_mem (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_start      (mem_start),
        .mem_addr       (mem_addr),
        .mem_ready      (mem_ready),
        .mem_data       (mem_data),
        .mem_data_valid (mem_data_valid)
    );

    decode_stage u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .id_pc     (id_pc),
        .id_inst   (id_inst),
        .dec_valid (dec_valid),
        .dec_pc    (dec_pc),
        .dec_inst  (dec_inst),
        .dec_rd    (dec_rd),
        .dec_rs1   (dec_rs1),
        .dec_imm   (dec_imm)
    );

endmodule

// ==== verif/frontend_chk.sv ====
module frontend_chk (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        stall,
    input  logic        redirect,
    input  logic        mem_start,
    input  logic        mem_ready,
    input  logic        mem_data_valid,
    input  logic        dec_valid,
    input  logic [31:0] dec_pc
);

    int   fail_count = 0;
    logic outstanding;

    // Set by an accepted request and cleared when its answer arrives
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= 1'b0;
        end else if (mem_start && mem_ready) begin
            outstanding <= 1'b1;
        end else if (mem_data_valid) begin
            outstanding <= 1'b0;
        end
    end

    a_valid_after_request: assert property (@(posedge clk) disable iff (!arst_n)
        mem_data_valid |-> outstanding)
    else begin
        $error("mem_data_valid came without an accepted request");
        fail_count++;
    end

    a_ready_low_when_busy: assert property (@(posedge clk) disable iff (!arst_n)
        (outstanding && !mem_data_valid) |-> !mem_ready)
    else begin
        $error("mem_ready was high while a request was outstanding");
        fail_count++;
    end

    // A held or squashed word leaves a bubble that reaches decode two cycles on
    a_bubble_on_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (stall || redirect) |-> ##2 !dec_valid)
    else begin
        $error("dec_valid was high two cycles after stall or redirect");
        fail_count++;
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        dec_valid |-> (dec_pc[1:0] == 2'b00))
    else begin
        $error("dec_pc was not word aligned");
        fail_count++;
    end

endmodule

// ==== verif/frontend_monitor.sv ====
module frontend_monitor import core_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        dec_valid,
    input  logic [31:0] dec_pc,
    input  logic [31:0] dec_inst,
    input  logic [4:0]  dec_rd,
    input  logic [4:0]  dec_rs1,
    input  logic [31:0] dec_imm,
    output int          dec_count,
    output int          err_count
);

    logic [31:0] prog [MEM_WORDS];
    logic [31:0] exp_pc;
    logic [31:0] exp_word;
    logic        redirect_due;
    logic [31:0] redirect_target;
    string       test_name = "reset";

    initial begin
        $readmemh("prog.hex", prog);
    end

    function automatic logic is_upper(input logic [31:0] word);
        return (word[6:0] == OPC_LUI) || (word[6:0] == OPC_AUIPC);
    endfunction

    task automatic check_field(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error [%s] %s: expected %h, actual %h",
                     test_name, field, expected, actual);
            err_count++;
        end
    endtask

    // Sampled on the falling edge, half a cycle away from any change
    always @(negedge clk) begin
        if (!arst_n) begin
            exp_pc       = RESET_PC;
            redirect_due = 1'b0;
            dec_count    = 0;
            err_count    = 0;
        end else begin
            if (dec_valid) begin
                exp_word = prog[exp_pc[6:2]];
                check_field("dec_pc", exp_pc, dec_pc);
                check_field("dec_inst", exp_word, dec_inst);
                check_field("dec_rd", {27'b0, exp_word[11:7]}, {27'b0, dec_rd});
                if (is_upper(exp_word)) begin
                    check_field("dec_rs1", 32'h0, {27'b0, dec_rs1});
                    check_field("dec_imm", {exp_word[31:12], 12'h000}, dec_imm);
                end else begin
                    check_field("dec_rs1", {27'b0, exp_word[19:15]}, {27'b0, dec_rs1});
                    check_field("dec_imm", {{20{exp_word[31]}}, exp_word[31:20]}, dec_imm);
                end
                exp_pc = exp_pc + 32'd4;
                dec_count++;
            end
            // The word sitting in the decode register during a redirect still comes out
            if (redirect_due) begin
                exp_pc       = redirect_target;
                redirect_due = 1'b0;
            end
            if (redirect) begin
                redirect_due    = 1'b1;
                redirect_target = redirect_pc;
            end
        end
    end

endmodule

// ==== verif/frontend_tb.sv ====
module frontend_tb import core_pkg::*; ();

    localparam int NUM_TESTS    = 6;
    localparam int STALL_NONE   = 0;
    localparam int STALL_GAP    = 1;
    localparam int STALL_RANDOM = 2;

    logic        clk;
    logic        arst_n;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        dec_valid;
    logic [31:0] dec_pc;
    logic [31:0] dec_inst;
    logic [4:0]  dec_rd;
    logic [4:0]  dec_rs1;
    logic [31:0] dec_imm;
    int          dec_count;
    int          err_count;

    // A redirect fires once the test has seen row_after decoded instructions
    string       row_name     [NUM_TESTS] = '{"seq_fetch", "gap_stall", "random_stall",
                                              "redirect", "redirect_wrap", "redirect_in_stall"};
    int          row_count    [NUM_TESTS] = '{32, 24, 32, 20, 12, 16};
    int          row_stall    [NUM_TESTS] = '{STALL_NONE, STALL_GAP, STALL_RANDOM,
                                              STALL_NONE, STALL_RANDOM, STALL_GAP};
    logic        row_redirect [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
    logic        row_held     [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    logic [31:0] row_target   [NUM_TESTS] = '{32'h0, 32'h0, 32'h0, 32'h0000_0010,
                                              32'h0000_0074, 32'h0000_0020};
    int          row_after    [NUM_TESTS] = '{0, 0, 0, 4, 3, 5};

    frontend_top dut0 (.*);

    frontend_monitor mon0 (.*);

    bind frontend_top frontend_chk chk0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .stall          (stall),
        .redirect       (redirect),
        .mem_start      (mem_start),
        .mem_ready      (mem_ready),
        .mem_data_valid (mem_data_valid),
        .dec_valid      (dec_valid),
        .dec_pc         (dec_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic drive(input logic stall_val, input logic redirect_val,
                         input logic [31:0] target);
        @(posedge clk);
        #2;
        stall       = stall_val;
        redirect    = redirect_val;
        redirect_pc = target;
    endtask

    function automatic logic stall_pattern(input int mode, input int cycle);
        if (mode == STALL_GAP) begin
            return (cycle % 5) < 2;
        end else if (mode == STALL_RANDOM) begin
            return ($urandom % 3) == 0;
        end
        return 1'b0;
    endfunction

    initial begin
        int   limit;
        limit = 3;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += row_count[t] * (MEM_LATENCY + 4) * 2;
        end
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles before all tests finished", limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int   start_count;
        int   start_errs;
        int   start_fails;
        int   test_errs;
        int   cycle;
        int   failed_tests;
        logic fired;

        void'($urandom(32'h437d_fb03));
        failed_tests = 0;
        arst_n       = 1'b0;
        stall        = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = 32'h0;
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            mon0.test_name = row_name[t];
            start_count    = dec_count;
            start_errs     = err_count;
            start_fails    = dut0.chk0.fail_count;
            fired          = 1'b0;
            cycle          = 0;
            while (dec_count - start_count < row_count[t]) begin
                if (row_redirect[t] && !fired && (dec_count - start_count >= row_after[t])) begin
                    fired = 1'b1;
                    if (row_held[t]) begin
                        // Long enough for the returning word to be saved before the squash
                        repeat (MEM_LATENCY + 2) drive(1'b1, 1'b0, 32'h0);
                        drive(1'b1, 1'b1, row_target[t]);
                    end else begin
                        drive(stall_pattern(row_stall[t], cycle), 1'b1, row_target[t]);
                    end
                end else begin
                    drive(stall_pattern(row_stall[t], cycle), 1'b0, 32'h0);
                end
                cycle++;
            end
            test_errs = (err_count - start_errs) + (dut0.chk0.fail_count - start_fails);
            if (test_errs != 0) begin
                failed_tests++;
            end
            $display("Test %s: %0d decoded, %0d errors", row_name[t],
                     dec_count - start_count, test_errs);
        end

        $display("Tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 NUM_TESTS, failed_tests, err_count, dut0.chk0.fail_count);
        if (failed_tests == 0 && err_count == 0 && dut0.chk0.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== prog.hex ====
// Two 32-bit instruction words per line, word address rising left to right
00500093 fff08113
123451b7 00001217
0ff17293 8001e313
fffff3b7 00c12403
55544493 80000517
f9c52593 000280e7
00abc637 7ff60693
00000013 7ffff717
fe070793 ffc78803
800008b7 4048d913
00391993 00000a17
001a0a93 0deadb37
eefb0b13 001b3b93
fffffc13 00001cb7
fffffd17 002d5d83
80000e13 123e6e93

// ==== build.f ====
hw/core_pkg.sv
hw/inst_mem.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/frontend_top.sv
verif/frontend_chk.sv
verif/frontend_monitor.sv
verif/frontend_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the front end testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module frontend_tb \
    -f build.f -o frontend_sim || { echo "Verilator build error"; exit 1; }

result=$(./obj_dir/frontend_sim +verilator+error+limit+1000 2>&1)
echo "$result"
echo "$result" | grep -qx "Simulation completed successfully" && exit 0 || exit 1
